// File: logic/nlc_pkg.sv
// Shared widths, fixed-point constants and types for the ADC corrector RTL and its testbench
package nlc_pkg;

	localparam int SAMPLE_W  = 21;
	localparam int FIX_W     = 32;
	localparam int FRAC_BITS = 16;
	localparam int NUM_COEFF = 6;
	localparam int MAX_CH    = 16;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [FIX_W-1:0]    fix_t;
	typedef logic [3:0]                 chan_idx_t;

	// Highest order first, so the set also reads as fix_t [NUM_COEFF-1:0]
	typedef struct packed {
		fix_t c5;
		fix_t c4;
		fix_t c3;
		fix_t c2;
		fix_t c1;
		fix_t c0;
	} coeff_set_t;

	typedef struct packed {
		sample_t    x_adc;
		fix_t       neg_mean;
		fix_t       recip_stdev;
		coeff_set_t coeffs;
	} chan_in_t;

	typedef enum logic {
		MODE_EXTERNAL,
		MODE_STORED
	} nlc_mode_e;

	typedef struct packed {
		nlc_mode_e                  mode;
		chan_in_t [MAX_CH-1:0]      ch;
	} frame_t;

	typedef struct packed {
		chan_idx_t channel;
		sample_t   x_lin;
	} result_t;

	typedef struct packed {
		fix_t      a;
		fix_t      b;
		fix_t      c;
		chan_idx_t tag;
	} mac_op_t;

	// Sweep order matters, the sequencer steps through these in sequence
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_NORM,
		SEQ_H5,
		SEQ_H4,
		SEQ_H3,
		SEQ_H2,
		SEQ_H1,
		SEQ_DRAIN
	} sweep_e;

endpackage

// File: logic/fixed_mac.sv
// Two-stage fixed-point multiply-add shared by all channels and sweeps
`timescale 1ns/1ps

module fixed_mac import nlc_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      issue_i,
	input  mac_op_t   op_i,
	output logic      done_o,
	output chan_idx_t tag_o,
	output fix_t      result_o
);

	logic signed [2*FIX_W-1:0] prod_q;
	logic signed [2*FIX_W-1:0] prod_shift;
	fix_t                      c_q;
	chan_idx_t                 tag1_q;
	logic                      vld1_q;
	fix_t                      res_q;
	chan_idx_t                 tag2_q;
	logic                      vld2_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			vld1_q <= 1'b0;
			vld2_q <= 1'b0;
		end else begin
			vld1_q <= issue_i;
			vld2_q <= vld1_q;
		end
	end

	assign prod_shift = prod_q >>> FRAC_BITS;

	always_ff @(posedge clk) begin
		prod_q <= $signed(op_i.a) * $signed(op_i.b);
		c_q    <= op_i.c;
		tag1_q <= op_i.tag;
		// Truncate to the working width and wrap on the add
		res_q  <= prod_shift[FIX_W-1:0] + c_q;
		tag2_q <= tag1_q;
	end

	assign done_o   = vld2_q;
	assign tag_o    = tag2_q;
	assign result_o = res_q;

endmodule

// File: logic/frame_buffer.sv
// Single input frame slot; holds one frame for the sequencer and returns the source credit
`timescale 1ns/1ps

module frame_buffer import nlc_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   in_valid_i,
	input  frame_t in_frame_i,
	output logic   in_credit_o,
	input  logic   take_i,
	output logic   full_o,
	output frame_t frame_o
);

	frame_t frame_q;
	logic   full_q;
	logic   init_q;
	logic   credit_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			full_q   <= 1'b0;
			init_q   <= 1'b0;
			credit_q <= 1'b0;
		end else begin
			init_q <= 1'b1;
			// First credit once out of reset, then one per emptied slot
			credit_q <= !init_q || take_i;
			if (in_valid_i)
				full_q <= 1'b1;
			else if (take_i)
				full_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid_i)
			frame_q <= in_frame_i;
	end

	assign in_credit_o = credit_q;
	assign full_o      = full_q;
	assign frame_o     = frame_q;

endmodule

// File: logic/coeff_bank.sv
// Per-channel polynomial coefficients; loaded from external-mode frames, read by channel and sweep
`timescale 1ns/1ps

module coeff_bank import nlc_pkg::*; #(
	parameter int NUM_CH = 16
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      load_i,
	input  frame_t    frame_i,
	input  chan_idx_t ch_i,
	input  sweep_e    sweep_i,
	output fix_t      coeff_a_o,
	output fix_t      coeff_c_o
);

	fix_t [NUM_COEFF-1:0]         mem [NUM_CH];
	logic [$clog2(NUM_COEFF)-1:0] c_sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_CH; i++)
				mem[i] <= '0;
		end else if (load_i && frame_i.mode == MODE_EXTERNAL) begin
			for (int i = 0; i < NUM_CH; i++)
				mem[i] <= frame_i.ch[i].coeffs;
		end
	end

	// Additive term steps down one order per Horner sweep
	always_comb begin
		case (sweep_i)
			SEQ_H5:  c_sel = 3'd4;
			SEQ_H4:  c_sel = 3'd3;
			SEQ_H3:  c_sel = 3'd2;
			SEQ_H2:  c_sel = 3'd1;
			default: c_sel = 3'd0;
		endcase
	end

	assign coeff_a_o = mem[ch_i][NUM_COEFF-1];
	assign coeff_c_o = mem[ch_i][c_sel];

endmodule

// File: logic/horner_sequencer.sv
// Sweep FSM; normalizes every channel then runs five Horner sweeps through the shared MAC
`timescale 1ns/1ps

module horner_sequencer import nlc_pkg::*; #(
	parameter int NUM_CH = 16
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      full_i,
	input  frame_t    frame_i,
	output logic      take_o,
	output chan_idx_t ch_o,
	output sweep_e    sweep_o,
	input  fix_t      coeff_a_i,
	input  fix_t      coeff_c_i,
	output logic      issue_o,
	output mac_op_t   op_o,
	input  logic      done_i,
	input  chan_idx_t tag_i,
	input  fix_t      result_i,
	input  logic      slot_avail_i,
	output logic      push_o,
	output result_t   push_data_o
);

	sweep_e    state;
	chan_idx_t ch_q;
	sweep_e    sw_d1;
	sweep_e    sw_d2;
	logic      last_ch;
	fix_t      norm_sum;

	sample_t x_mem        [NUM_CH];
	fix_t    neg_mean_mem [NUM_CH];
	fix_t    recip_mem    [NUM_CH];
	fix_t    z_mem        [NUM_CH];
	fix_t    acc_mem      [NUM_CH];

	assign take_o  = (state == SEQ_IDLE) && full_i;
	assign last_ch = (ch_q == chan_idx_t'(NUM_CH - 1));

	// Final sweep waits for a reserved output slot
	always_comb begin
		case (state)
			SEQ_NORM, SEQ_H5, SEQ_H4, SEQ_H3, SEQ_H2: issue_o = 1'b1;
			SEQ_H1:  issue_o = slot_avail_i;
			default: issue_o = 1'b0;
		endcase
	end

	assign norm_sum = fix_t'(x_mem[ch_q]) + neg_mean_mem[ch_q];

	always_comb begin
		op_o.tag = ch_q;
		op_o.b   = z_mem[ch_q];
		op_o.c   = coeff_c_i;
		case (state)
			SEQ_NORM: begin
				op_o.a = norm_sum;
				op_o.b = recip_mem[ch_q];
				op_o.c = '0;
			end
			SEQ_H5:  op_o.a = coeff_a_i;
			default: op_o.a = acc_mem[ch_q];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			ch_q  <= '0;
			sw_d1 <= SEQ_IDLE;
			sw_d2 <= SEQ_IDLE;
		end else begin
			// Sweep label follows each op through the two MAC stages
			sw_d1 <= state;
			sw_d2 <= sw_d1;
			case (state)
				SEQ_IDLE: begin
					ch_q <= '0;
					if (full_i)
						state <= SEQ_NORM;
				end
				SEQ_DRAIN: begin
					if (done_i && sw_d2 == SEQ_H1 && tag_i == chan_idx_t'(NUM_CH - 1))
						state <= SEQ_IDLE;
				end
				default: begin
					if (issue_o) begin
						ch_q <= last_ch ? '0 : ch_q + 1'b1;
						if (last_ch)
							state <= sweep_e'(state + 3'd1);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_o) begin
			for (int i = 0; i < NUM_CH; i++) begin
				x_mem[i]        <= frame_i.ch[i].x_adc;
				neg_mean_mem[i] <= frame_i.ch[i].neg_mean;
				recip_mem[i]    <= frame_i.ch[i].recip_stdev;
			end
		end
		if (done_i) begin
			if (sw_d2 == SEQ_NORM)
				z_mem[tag_i] <= result_i;
			else if (sw_d2 != SEQ_H1)
				acc_mem[tag_i] <= result_i;
		end
	end

	assign push_o              = done_i && (sw_d2 == SEQ_H1);
	assign push_data_o.channel = tag_i;
	assign push_data_o.x_lin   = result_i[SAMPLE_W-1:0];

	assign ch_o    = ch_q;
	assign sweep_o = state;

endmodule

// File: logic/result_queue.sv
// Output FIFO with slot reservation; sends corrected samples against consumer credits
`timescale 1ns/1ps

module result_queue import nlc_pkg::*; #(
	parameter int OUT_CREDITS = 4,
	parameter int NUM_CH      = 16
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    reserve_i,
	output logic    slot_avail_o,
	input  logic    push_i,
	input  result_t push_data_i,
	output logic    out_valid_o,
	output result_t out_result_o,
	input  logic    out_credit_i
);

	localparam int PTR_W  = $clog2(NUM_CH);
	localparam int CNT_W  = $clog2(NUM_CH + 1);
	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	result_t           mem [NUM_CH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  stored_cnt;
	logic [CNT_W-1:0]  reserved_cnt;
	logic [CRED_W-1:0] credit_cnt;
	logic              pop;

	// A reservation turns into a stored entry when its result is pushed
	assign slot_avail_o = (stored_cnt + reserved_cnt) < NUM_CH;
	assign pop          = (stored_cnt != '0) && (credit_cnt != '0);
	assign out_valid_o  = pop;
	assign out_result_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			stored_cnt   <= '0;
			reserved_cnt <= '0;
			credit_cnt   <= CRED_W'(OUT_CREDITS);
		end else begin
			if (push_i)
				wr_ptr <= (wr_ptr == PTR_W'(NUM_CH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(NUM_CH - 1)) ? '0 : rd_ptr + 1'b1;
			stored_cnt   <= stored_cnt + CNT_W'(push_i) - CNT_W'(pop);
			reserved_cnt <= reserved_cnt + CNT_W'(reserve_i) - CNT_W'(push_i);
			credit_cnt   <= credit_cnt + CRED_W'(out_credit_i) - CRED_W'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr] <= push_data_i;
	end

endmodule

// File: logic/nlc_top.sv
// Top level of the corrector; connects frame slot, coefficient bank, sequencer, MAC and result FIFO
`timescale 1ns/1ps

module nlc_top import nlc_pkg::*; #(
	parameter int NUM_CH      = 16,
	parameter int OUT_CREDITS = 4
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    in_valid_i,
	input  frame_t  in_frame_i,
	output logic    in_credit_o,
	output logic    out_valid_o,
	output result_t out_result_o,
	input  logic    out_credit_i
);

	frame_t    fb_frame;
	logic      fb_full;
	logic      seq_take;
	chan_idx_t seq_ch;
	sweep_e    seq_sweep;
	fix_t      coeff_a;
	fix_t      coeff_c;
	logic      mac_issue;
	mac_op_t   mac_op;
	logic      mac_done;
	chan_idx_t mac_tag;
	fix_t      mac_result;
	logic      q_slot_avail;
	logic      q_reserve;
	logic      seq_push;
	result_t   seq_push_data;

	// Only final-sweep issues claim an output slot
	assign q_reserve = mac_issue && (seq_sweep == SEQ_H1);

	frame_buffer i_frame_buffer (
		.clk         (clk),
		.reset       (reset),
		.in_valid_i  (in_valid_i),
		.in_frame_i  (in_frame_i),
		.in_credit_o (in_credit_o),
		.take_i      (seq_take),
		.full_o      (fb_full),
		.frame_o     (fb_frame)
	);

	coeff_bank #(.NUM_CH(NUM_CH)) i_coeff_bank (
		.clk       (clk),
		.reset     (reset),
		.load_i    (seq_take),
		.frame_i   (fb_frame),
		.ch_i      (seq_ch),
		.sweep_i   (seq_sweep),
		.coeff_a_o (coeff_a),
		.coeff_c_o (coeff_c)
	);

	horner_sequencer #(.NUM_CH(NUM_CH)) i_horner_sequencer (
		.clk          (clk),
		.reset        (reset),
		.full_i       (fb_full),
		.frame_i      (fb_frame),
		.take_o       (seq_take),
		.ch_o         (seq_ch),
		.sweep_o      (seq_sweep),
		.coeff_a_i    (coeff_a),
		.coeff_c_i    (coeff_c),
		.issue_o      (mac_issue),
		.op_o         (mac_op),
		.done_i       (mac_done),
		.tag_i        (mac_tag),
		.result_i     (mac_result),
		.slot_avail_i (q_slot_avail),
		.push_o       (seq_push),
		.push_data_o  (seq_push_data)
	);

	fixed_mac i_fixed_mac (
		.clk      (clk),
		.reset    (reset),
		.issue_i  (mac_issue),
		.op_i     (mac_op),
		.done_o   (mac_done),
		.tag_o    (mac_tag),
		.result_o (mac_result)
	);

	result_queue #(
		.OUT_CREDITS (OUT_CREDITS),
		.NUM_CH      (NUM_CH)
	) i_result_queue (
		.clk          (clk),
		.reset        (reset),
		.reserve_i    (q_reserve),
		.slot_avail_o (q_slot_avail),
		.push_i       (seq_push),
		.push_data_i  (seq_push_data),
		.out_valid_o  (out_valid_o),
		.out_result_o (out_result_o),
		.out_credit_i (out_credit_i)
	);

endmodule

// File: verif/nlc_asserts.sv
// Bound checks on credit use and occupancy of the result FIFO and of the input frame slot
`timescale 1ns/1ps

module nlc_asserts #(
	parameter int LIMIT        = 16,
	parameter int INIT_CREDITS = 0
) (
	input logic        clk,
	input logic        reset,
	input logic        fire_i,
	input logic        credit_i,
	input logic [31:0] level_i
);

	int fail_cnt = 0;
	int held;

	// Credits granted to the sender and not yet spent
	always_ff @(posedge clk) begin
		if (reset)
			held <= INIT_CREDITS;
		else
			held <= held + int'(credit_i) - int'(fire_i);
	end

	a_fire_credit: assert property (@(posedge clk) disable iff (reset) fire_i |-> held > 0)
		else begin
			fail_cnt++;
			$error("transfer with no credit held");
		end

	a_level_limit: assert property (@(posedge clk) disable iff (reset) level_i <= LIMIT)
		else begin
			fail_cnt++;
			$error("occupancy %0d above limit %0d", level_i, LIMIT);
		end

endmodule

// Stored plus reserved entries never exceed the FIFO depth
bind result_queue nlc_asserts #(
	.LIMIT        (NUM_CH),
	.INIT_CREDITS (OUT_CREDITS)
) i_queue_asserts (
	.clk      (clk),
	.reset    (reset),
	.fire_i   (out_valid_o),
	.credit_i (out_credit_i),
	.level_i  (32'(stored_cnt) + 32'(reserved_cnt))
);

// An arriving frame counts against the single slot
bind frame_buffer nlc_asserts #(
	.LIMIT        (1),
	.INIT_CREDITS (0)
) i_slot_asserts (
	.clk      (clk),
	.reset    (reset),
	.fire_i   (in_valid_i),
	.credit_i (in_credit_o),
	.level_i  (32'(full_o) + 32'(in_valid_i))
);

// File: verif/nlc_model.svh
// Reference arithmetic and coefficient memory of the corrector, included inside the testbench module
`ifndef NLC_MODEL_SVH
`define NLC_MODEL_SVH

// Coefficients of the most recent external-mode frame, zero until one arrives
coeff_set_t model_coeffs [MAX_CH];

function automatic fix_t mac_ref(input fix_t a, input fix_t b, input fix_t c);
	longint prod;
	longint scaled;
	prod   = longint'(a) * longint'(b);
	scaled = prod >>> FRAC_BITS;
	return fix_t'(scaled[FIX_W-1:0]) + c;
endfunction

function automatic sample_t correct_sample(input chan_in_t ci, input coeff_set_t cs);
	fix_t z;
	fix_t acc;
	z   = mac_ref(fix_t'(ci.x_adc) + ci.neg_mean, ci.recip_stdev, '0);
	// Horner from the highest order down
	acc = mac_ref(cs.c5, z, cs.c4);
	acc = mac_ref(acc, z, cs.c3);
	acc = mac_ref(acc, z, cs.c2);
	acc = mac_ref(acc, z, cs.c1);
	acc = mac_ref(acc, z, cs.c0);
	return sample_t'(acc[SAMPLE_W-1:0]);
endfunction

function void clear_model_coeffs();
	for (int i = 0; i < MAX_CH; i++)
		model_coeffs[i] = '0;
endfunction

function void load_model_coeffs(input frame_t f);
	if (f.mode == MODE_EXTERNAL) begin
		for (int i = 0; i < MAX_CH; i++)
			model_coeffs[i] = f.ch[i].coeffs;
	end
endfunction

function automatic result_t model_result(input frame_t f, input int ch);
	result_t r;
	r.channel = chan_idx_t'(ch);
	r.x_lin   = correct_sample(f.ch[ch], model_coeffs[ch]);
	return r;
endfunction

`endif

// File: verif/nlc_tb.sv
// Testbench for the ADC corrector; random frames and consumer credits checked against a model
`timescale 1ns/1ps

module nlc_tb
	import nlc_pkg::*;
();

	localparam int NUM_CH      = 16;
	localparam int OUT_CREDITS = 4;
	localparam int NUM_FRAMES  = 24;
	localparam int SEED        = 34;
	localparam int WAIT_LIMIT  = 20000;
	localparam int DRAIN_LIMIT = 100000;

	logic    clk;
	logic    reset      = 1'b1;
	logic    in_valid   = 1'b0;
	frame_t  in_frame   = '0;
	logic    in_credit;
	logic    out_valid;
	result_t out_result;
	logic    out_credit = 1'b0;

	int in_credits_seen  = 0;
	int credits_returned = 0;
	int results_seen     = 0;
	int owed             = 0;
	int gap              = 0;
	int overruns         = 0;
	int errors           = 0;
	int tests_run        = 0;
	int tests_failed     = 0;
	int frame_err_base   = 0;
	int frames_sent      = 0;
	int overlap_sends    = 0;
	bit timed_out        = 1'b0;

	result_t   exp_q  [$];
	nlc_mode_e mode_q [$];

	`include "nlc_model.svh"

	nlc_top i_dut (
		.clk          (clk),
		.reset        (reset),
		.in_valid_i   (in_valid),
		.in_frame_i   (in_frame),
		.in_credit_o  (in_credit),
		.out_valid_o  (out_valid),
		.out_result_o (out_result),
		.out_credit_i (out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic compare_result(input string name, input result_t exp, input result_t act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected ch %0d x_lin %0d actual ch %0d x_lin %0d",
				name, exp.channel, exp.x_lin, act.channel, act.x_lin);
		end
	endtask

	task automatic verify_count(input string name, input int exp, input int act);
		if (exp != act) begin
			errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_base);
		tests_run++;
		if (errors == err_base) begin
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - err_base);
		end
	endtask

	function automatic fix_t random_coeff();
		return fix_t'(int'($urandom_range(0, 131072)) - 65536);
	endfunction

	function automatic frame_t random_frame(input bit external);
		frame_t frm;
		frm      = '0;
		frm.mode = (external || $urandom_range(0, 1) == 0) ? MODE_EXTERNAL : MODE_STORED;
		for (int i = 0; i < MAX_CH; i++) begin
			frm.ch[i].x_adc       = sample_t'(int'($urandom_range(0, 8191)) - 4096);
			frm.ch[i].neg_mean    = fix_t'(int'($urandom_range(0, 8191)) - 4096);
			frm.ch[i].recip_stdev = fix_t'($urandom_range(0, 262143));
			frm.ch[i].coeffs.c0   = random_coeff();
			frm.ch[i].coeffs.c1   = random_coeff();
			frm.ch[i].coeffs.c2   = random_coeff();
			frm.ch[i].coeffs.c3   = random_coeff();
			frm.ch[i].coeffs.c4   = random_coeff();
			frm.ch[i].coeffs.c5   = random_coeff();
		end
		return frm;
	endfunction

	// Mostly short gaps, now and then a long stall of the consumer
	function automatic int pick_credit_gap();
		if ($urandom_range(0, 7) == 0)
			return int'($urandom_range(30, 80));
		return int'($urandom_range(0, 3));
	endfunction

	task automatic wait_input_credit(input int need);
		int cycles;
		cycles = 0;
		while (in_credits_seen < need && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (in_credits_seen < need) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: no input credit for frame %0d within %0d cycles",
				frames_sent, WAIT_LIMIT);
		end
	endtask

	task automatic wait_results(input int need);
		int cycles;
		cycles = 0;
		while (results_seen < need && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (results_seen < need) begin
			errors++;
			timed_out = 1'b1;
			$display("timeout: only %0d of %0d results arrived", results_seen, need);
		end
	endtask

	task automatic check_output();
		result_t   exp;
		nlc_mode_e m;
		int        frame_idx;
		int        ch_idx;
		frame_idx = results_seen / NUM_CH;
		ch_idx    = results_seen % NUM_CH;
		if (ch_idx == 0)
			frame_err_base = errors;
		if (results_seen + 1 > OUT_CREDITS + credits_returned) begin
			overruns++;
			errors++;
			$display("result %0d was sent with no consumer credit left", results_seen);
		end
		if (exp_q.size() == 0) begin
			errors++;
			$display("result on channel %0d arrived with no result expected", out_result.channel);
		end else begin
			exp = exp_q.pop_front();
			compare_result($sformatf("frame_%0d ch_%0d", frame_idx, ch_idx), exp, out_result);
		end
		if (ch_idx == NUM_CH - 1 && mode_q.size() > 0) begin
			m = mode_q.pop_front();
			report_test($sformatf("frame_%0d_%s", frame_idx,
				(m == MODE_EXTERNAL) ? "external" : "stored"), frame_err_base);
		end
		results_seen <= results_seen + 1;
	endtask

	// Output monitor and consumer; each result owes one credit back after a random gap
	always @(posedge clk) begin
		int delta;
		delta = 0;
		out_credit <= 1'b0;
		if (!reset) begin
			if (in_credit)
				in_credits_seen <= in_credits_seen + 1;
			if (out_credit)
				credits_returned <= credits_returned + 1;
			if (out_valid) begin
				check_output();
				delta++;
			end
			if (owed > 0) begin
				if (gap == 0) begin
					out_credit <= 1'b1;
					delta--;
					gap <= pick_credit_gap();
				end else begin
					gap <= gap - 1;
				end
			end
			owed <= owed + delta;
		end
	end

	initial begin
		frame_t frm;
		int     base;
		void'($urandom(SEED));
		clear_model_coeffs();
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		base = errors;
		wait_input_credit(1);
		repeat (8) @(posedge clk);
		verify_count("reset_idle input credits", 1, in_credits_seen);
		verify_count("reset_idle results", 0, results_seen);
		report_test("reset_idle", base);

		for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
			wait_input_credit(frames_sent + 1);
			if (!timed_out) begin
				frm = random_frame(f == 0);
				if (exp_q.size() > 0)
					overlap_sends++;
				load_model_coeffs(frm);
				for (int c = 0; c < NUM_CH; c++)
					exp_q.push_back(model_result(frm, c));
				mode_q.push_back(frm.mode);
				in_valid <= 1'b1;
				in_frame <= frm;
				@(posedge clk);
				in_valid <= 1'b0;
				frames_sent++;
			end
		end

		if (!timed_out) begin
			wait_results(NUM_FRAMES * NUM_CH);
			repeat (50) @(posedge clk);
		end

		base = errors;
		verify_count("output_flow results", NUM_FRAMES * NUM_CH, results_seen);
		verify_count("output_flow leftover", 0, exp_q.size());
		verify_count("output_flow overruns", 0, overruns);
		report_test("output_flow", base);

		base = errors;
		verify_count("input credits", frames_sent + 1, in_credits_seen);
		verify_count("frames sent", NUM_FRAMES, frames_sent);
		if (overlap_sends == 0) begin
			errors++;
			$display("no frame was sent while earlier results were still pending");
		end
		report_test("input_credits", base);

		base = errors;
		verify_count("assertion failures", 0,
			i_dut.i_result_queue.i_queue_asserts.fail_cnt +
			i_dut.i_frame_buffer.i_slot_asserts.fail_cnt);
		report_test("assertions", base);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+verif
logic/nlc_pkg.sv
logic/fixed_mac.sv
logic/frame_buffer.sv
logic/coeff_bank.sv
logic/horner_sequencer.sv
logic/result_queue.sv
logic/nlc_top.sv
verif/nlc_asserts.sv
verif/nlc_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module nlc_tb -f tb.f -o nlc_sim \
	&& ./obj_dir/nlc_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1
